//--- bench/tb_exec_vectors.svh
/*
 * Directed operations for the execute stage testbench, one add_vec call each.
 * Columns: unit, code, op_a, op_b, op_c, npc, result, result_aux,
 * {jump, we_rf, mem_rd}, mem_addr, we_mem. The tag is the entry index.
 */
`ifndef TB_EXEC_VECTORS_SVH
`define TB_EXEC_VECTORS_SVH

task automatic load_table;
    // ALU and shifter
    add_vec(XU_ALU,   OP_SLT,  'hFFFFFFFF, 1, 0, 0, 1, 0, 3'b010, 0, 4'h0);  // -1 < 1 signed
    add_vec(XU_ALU,   OP_SLTU, 'hFFFFFFFF, 1, 0, 0, 0, 0, 3'b010, 0, 4'h0);  // Huge unsigned
    add_vec(XU_SHIFT, OP_SRA,  'h80000010, 'h24, 0, 0, 'hF8000001, 0, 3'b010, 0, 4'h0);
    add_vec(XU_SHIFT, OP_SRL,  'h80000010, 'h24, 0, 0, 'h08000001, 0, 3'b010, 0, 4'h0);
    add_vec(XU_SHIFT, OP_SLL,  1, 31, 0, 0, 'h80000000, 0, 3'b010, 0, 4'h0);
    add_vec(XU_ALU,   OP_ADD,  'hFFFFFFFF, 2, 0, 0, 1, 0, 3'b010, 0, 4'h0);  // Wraps to 1
    add_vec(XU_ALU,   OP_SUB,  0, 1, 0, 0, 'hFFFFFFFF, 0, 3'b010, 0, 4'h0);  // Wraps to -1
    // Branches at pc 0x100, offset 0x10
    add_vec(XU_BRANCH, OP_BEQ,  5, 5, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BEQ,  5, 6, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BNE,  5, 6, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BNE,  5, 5, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BLT,  'hFFFFFFFF, 1, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BLT,  1, 'hFFFFFFFF, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BGE,  1, 'hFFFFFFFF, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BGE,  'hFFFFFFFF, 1, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BLTU, 1, 'hFFFFFFFF, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BLTU, 'hFFFFFFFF, 1, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BGEU, 'hFFFFFFFF, 1, 'h10, 'h104, 0, 'h110, 3'b100, 0, 4'h0);
    add_vec(XU_BRANCH, OP_BGEU, 1, 'hFFFFFFFF, 'h10, 'h104, 0, 'h110, 3'b000, 0, 4'h0);
    add_vec(XU_BRANCH, OP_JAL,  0, 0, 'hFFFFFFF8, 'h204, 'h204, 'h1F8, 3'b110, 0, 4'h0);
    add_vec(XU_BRANCH, OP_JALR, 'h1001, 0, 'h10, 'h308, 'h308, 'h1010, 3'b110, 0, 4'h0);
    // Stores at every byte offset, then loads
    add_vec(XU_LSU, OP_SB, 'h100, 0, 'hAB, 0, 'hAB, 'h100, 3'b000, 'h100, 4'h1);
    add_vec(XU_LSU, OP_SB, 'h100, 1, 'hAB, 0, 'hAB00, 'h101, 3'b000, 'h101, 4'h2);
    add_vec(XU_LSU, OP_SB, 'h100, 2, 'hAB, 0, 'hAB0000, 'h102, 3'b000, 'h102, 4'h4);
    add_vec(XU_LSU, OP_SB, 'h100, 3, 'hAB, 0, 'hAB000000, 'h103, 3'b000, 'h103, 4'h8);
    add_vec(XU_LSU, OP_SH, 'h100, 0, 'h1234, 0, 'h1234, 'h100, 3'b000, 'h100, 4'h3);
    add_vec(XU_LSU, OP_SH, 'h100, 1, 'h1234, 0, 'h123400, 'h101, 3'b000, 'h101, 4'h3);
    add_vec(XU_LSU, OP_SH, 'h100, 2, 'h1234, 0, 'h12340000, 'h102, 3'b000, 'h102, 4'hC);
    add_vec(XU_LSU, OP_SH, 'h100, 3, 'h1234, 0, 'h34000000, 'h103, 3'b000, 'h103, 4'hC);
    add_vec(XU_LSU, OP_SW, 'h100, 0, 'hDEADBEEF, 0, 'hDEADBEEF, 'h100, 3'b000, 'h100, 4'hF);
    add_vec(XU_LSU, OP_SW, 'h100, 1, 'hDEADBEEF, 0, 'hADBEEF00, 'h101, 3'b000, 'h101, 4'hF);
    add_vec(XU_LSU, OP_SW, 'h100, 2, 'hDEADBEEF, 0, 'hBEEF0000, 'h102, 3'b000, 'h102, 4'hF);
    add_vec(XU_LSU, OP_SW, 'h100, 3, 'hDEADBEEF, 0, 'hEF000000, 'h103, 3'b000, 'h103, 4'hF);
    add_vec(XU_LSU, OP_LW, 'h2000, 8, 0, 0, 0, 'h2008, 3'b011, 'h2008, 4'h0);
    add_vec(XU_LSU, OP_LB, 'h2000, 'hFFFFFFFF, 'h55, 0, 0, 'h1FFF, 3'b011, 'h1FFF, 4'h0);
    // Bypass
    add_vec(XU_BYPASS, OP_NOP, 1, 'hCAFEF00D, 2, 'h40, 'hCAFEF00D, 0, 3'b010, 0, 4'h0);
endtask

`endif

//--- bench/tb_exec_top.sv
/*
 * Testbench for the execute stage top level. Applies the directed table
 * under random output back-pressure and checks every completed transfer.
 */
`timescale 1ns/100ps

module tb_exec_top;
    import exec_pkg::*;

    localparam int RST_CYC = 10;            // Reset length in cycles

    typedef struct packed {
        xu_sel_e     sel;
        exec_op_e    op;
        logic [31:0] a, b, c, npc;          // Stimulus
        logic [31:0] res, aux, addr;        // Expected result, result_aux, mem_addr
        logic [2:0]  flags;                 // {jump, we_rf, mem_rd}
        logic [3:0]  mask;                  // Expected we_mem
    } vec_t;

    logic        clk = 1'b0;
    logic        out_ready_i = 1'b0;        // Random back-pressure
    logic        rst_n_i, in_valid_i;
    xu_sel_e     xu_sel_i;
    exec_op_e    op_i;
    logic [31:0] op_a_i, op_b_i, op_c_i, npc_i;
    logic [3:0]  tag_i, tag_o, we_mem_o;
    logic        in_ready_o, out_valid_o, jump_o, we_rf_o, mem_rd_o;
    logic [31:0] result_o, result_aux_o, mem_addr_o;

    vec_t        vecs[$];                   // Operation table
    int          errors = 0;
    int          out_idx = 0;               // Next expected output entry
    int          cycles = 0;
    int          limit;                     // Timeout in cycles
    bit          accepted_any = 1'b0;       // First transfer seen
    bit          held = 1'b0;               // Last cycle was a stall
    bit          exp_full = 1'b0;           // Modelled output register occupancy
    bit          exp_ready;                 // Expected in_ready_o this cycle
    logic [31:0] snap_res, snap_aux, snap_addr;
    logic [11:0] snap_ctl;                  // Valid, flags, mask, tag

    exec_top u_dut (.*);                    // Default widths

    always #5 clk = ~clk;                   // 10 ns period

    initial begin                           // Back-pressure source
        void'($urandom(36));                // Single seed for the run
        forever begin
            @(posedge clk);
            out_ready_i <= ($urandom_range(2) != 0); // Low one cycle in three
        end
    end

    task automatic add_vec(input xu_sel_e sel, input exec_op_e op,
                           input logic [31:0] a, b, c, npc, res, aux,
                           input logic [2:0] flags, input logic [31:0] addr,
                           input logic [3:0] mask);
        vecs.push_back('{sel, op, a, b, c, npc, res, aux, addr, flags, mask});
    endtask

    `include "tb_exec_vectors.svh"

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic finish_run;
        $display("%0d of %0d operations checked, %0d errors", out_idx, vecs.size(), errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////
    initial begin
        rst_n_i    = 1'b0;
        in_valid_i = 1'b0;
        xu_sel_i   = XU_ALU;
        op_i       = OP_NOP;
        tag_i      = '0;
        {op_a_i, op_b_i, op_c_i, npc_i} = '0;
        load_table;
        limit = 20 * vecs.size() + RST_CYC;
        repeat (RST_CYC) @(posedge clk);
        rst_n_i <= 1'b1;
        for (int i = 0; i < vecs.size(); i++) begin
            @(posedge clk);                 // Previous entry taken here
            in_valid_i <= 1'b1;
            xu_sel_i   <= vecs[i].sel;
            op_i       <= vecs[i].op;
            op_a_i     <= vecs[i].a;
            op_b_i     <= vecs[i].b;
            op_c_i     <= vecs[i].c;
            npc_i      <= vecs[i].npc;
            tag_i      <= i[3:0];
            @(negedge clk);
            while (!in_ready_o) @(negedge clk); // Held until ready
        end
        @(posedge clk);
        in_valid_i <= 1'b0;
        wait (out_idx == vecs.size());
        finish_run;
    end

    ////////////////////////////////////////
    // Output monitor, sampled mid-cycle
    ////////////////////////////////////////
    always @(negedge clk) begin
        cycles++;
        exp_ready = !exp_full || out_ready_i; // Empty or draining
        check_value("out_valid_o", 32'(out_valid_o), 32'(exp_full));
        check_value("in_ready_o", 32'(in_ready_o), 32'(exp_ready));
        if (!accepted_any) begin            // Reset state until the first transfer
            check_value("out_valid_o/jump_o/we_rf_o/mem_rd_o/we_mem_o",
                        32'({out_valid_o, jump_o, we_rf_o, mem_rd_o, we_mem_o}), 0);
        end
        accepted_any = accepted_any || (in_valid_i && in_ready_o);
        if (held) begin                     // Register frozen under back-pressure
            check_value("result_o during stall", result_o, snap_res);
            check_value("result_aux_o during stall", result_aux_o, snap_aux);
            check_value("mem_addr_o during stall", mem_addr_o, snap_addr);
            check_value("control outputs during stall",
                        32'({out_valid_o, jump_o, we_rf_o, mem_rd_o, we_mem_o, tag_o}),
                        32'(snap_ctl));
        end
        if (rst_n_i && out_valid_o && out_ready_i) begin
            if (out_idx >= vecs.size()) begin
                errors++;
                $display("Extra output at %0t ns after all operations came out", $time);
            end else begin
                check_value("result_o", result_o, vecs[out_idx].res);
                check_value("result_aux_o", result_aux_o, vecs[out_idx].aux);
                check_value("mem_addr_o", mem_addr_o, vecs[out_idx].addr);
                check_value("jump_o", 32'(jump_o), 32'(vecs[out_idx].flags[2]));
                check_value("we_rf_o", 32'(we_rf_o), 32'(vecs[out_idx].flags[1]));
                check_value("mem_rd_o", 32'(mem_rd_o), 32'(vecs[out_idx].flags[0]));
                check_value("we_mem_o", 32'(we_mem_o), 32'(vecs[out_idx].mask));
                check_value("tag_o", 32'(tag_o), 32'(out_idx % 16)); // Order and tag
                out_idx++;
            end
        end
        held      = rst_n_i && out_valid_o && !out_ready_i;
        snap_res  = result_o;
        snap_aux  = result_aux_o;
        snap_addr = mem_addr_o;
        snap_ctl  = {out_valid_o, jump_o, we_rf_o, mem_rd_o, we_mem_o, tag_o};
        if (!rst_n_i) begin                 // Occupancy after the coming edge
            exp_full = 1'b0;
        end else if (in_valid_i && exp_ready) begin
            exp_full = 1'b1;                // Visible one cycle after the transfer
        end else if (out_ready_i) begin
            exp_full = 1'b0;
        end
        if (cycles > limit) begin
            errors++;
            $display("Timeout after %0d cycles, only %0d of %0d operations came out",
                     cycles, out_idx, vecs.size());
            finish_run;
        end
    end

endmodule

//--- design/alu_unit.sv
/*
 * Combinational arithmetic and logic unit.
 * Add, subtract, signed and unsigned set-less-than, and bitwise logic.
 */
`timescale 1ns/100ps

module alu_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEF
) (
    exec_op_if.unit         ops,            // Gated operation from dispatcher
    output logic [XLEN-1:0] result_o        // Combinational result
);
    import exec_pkg::*;

    logic [XLEN-1:0] sum;                   // op_a + op_b
    logic [XLEN-1:0] diff;                  // op_a - op_b
    logic            lt_s;                  // Signed less than
    logic            lt_u;                  // Unsigned less than

    ////////////////////////////////////////
    // Shared arithmetic
    ////////////////////////////////////////
    assign sum  = ops.op_a + ops.op_b;      // Wraps at XLEN
    assign diff = ops.op_a - ops.op_b;      // Wraps at XLEN
    assign lt_s = $signed(ops.op_a) < $signed(ops.op_b);
    assign lt_u = ops.op_a < ops.op_b;

    ////////////////////////////////////////
    // Result select
    ////////////////////////////////////////
    always_comb begin
        result_o = '0;                      // NOP and foreign codes give zero
        case (ops.op)
            OP_ADD: begin
                result_o = sum;
            end
            OP_SUB: begin
                result_o = diff;
            end
            OP_SLT: begin
                result_o = {{(XLEN-1){1'b0}}, lt_s}; // 1 or 0
            end
            OP_SLTU: begin
                result_o = {{(XLEN-1){1'b0}}, lt_u};
            end
            OP_XOR: begin
                result_o = ops.op_a ^ ops.op_b;
            end
            OP_OR: begin
                result_o = ops.op_a | ops.op_b;
            end
            OP_AND: begin
                result_o = ops.op_a & ops.op_b;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

//--- design/branch_unit.sv
/*
 * Branch comparison, branch target and jump-and-link.
 * Jumps and links return npc as the write-back value.
 */
`timescale 1ns/100ps

module branch_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEF
) (
    exec_op_if.unit         ops,            // Gated operation from dispatcher
    output logic [XLEN-1:0] result_o,       // Link value
    output logic [XLEN-1:0] target_o,       // Jump target
    output logic            jump_o,         // Taken flag
    output logic            we_rf_o         // Link write enable
);
    import exec_pkg::*;

    logic            eq;                    // op_a == op_b
    logic            lt_s;                  // Signed less than
    logic            lt_u;                  // Unsigned less than
    logic [XLEN-1:0] pc_rel;                // PC of branch plus offset
    logic [XLEN-1:0] reg_rel;               // Register plus offset

    assign eq      = ops.op_a == ops.op_b;
    assign lt_s    = $signed(ops.op_a) < $signed(ops.op_b);
    assign lt_u    = ops.op_a < ops.op_b;
    assign pc_rel  = ops.npc - XLEN'(4) + ops.op_c; // npc is PC + 4
    assign reg_rel = ops.op_a + ops.op_c;

    ////////////////////////////////////////
    // Condition and target
    ////////////////////////////////////////
    always_comb begin
        result_o = '0;
        target_o = pc_rel;
        jump_o   = 1'b0;
        we_rf_o  = 1'b0;
        case (ops.op)
            OP_BEQ:  jump_o = eq;
            OP_BNE:  jump_o = !eq;
            OP_BLT:  jump_o = lt_s;
            OP_BGE:  jump_o = !lt_s;
            OP_BLTU: jump_o = lt_u;
            OP_BGEU: jump_o = !lt_u;
            OP_JAL: begin
                jump_o   = 1'b1;
                result_o = ops.npc;         // Return address
                we_rf_o  = 1'b1;
            end
            OP_JALR: begin
                jump_o   = 1'b1;
                target_o = {reg_rel[XLEN-1:1], 1'b0}; // Bit 0 cleared
                result_o = ops.npc;
                we_rf_o  = 1'b1;
            end
            default: begin
                jump_o = 1'b0;              // Idle unit never jumps
            end
        endcase
    end

endmodule

//--- design/exec_op_if.sv
/*
 * Operand bundle for one operation: code, three operands and next PC.
 * The src side drives it, a stage or functional unit reads it as unit.
 */
`timescale 1ns/100ps

interface exec_op_if #(
    parameter int XLEN = exec_pkg::XLEN_DEF
);
    import exec_pkg::*;

    exec_op_e         op;                   // Operation code, OP_NOP when idle
    logic [XLEN-1:0]  op_a;                 // First source operand
    logic [XLEN-1:0]  op_b;                 // Second source operand
    logic [XLEN-1:0]  op_c;                 // Offset or store data
    logic [XLEN-1:0]  npc;                  // Next PC of this instruction

    // Producer side
    modport src (
        output op, op_a, op_b, op_c, npc
    );

    // Consumer side
    modport unit (
        input  op, op_a, op_b, op_c, npc
    );

endinterface

//--- design/exec_pkg.sv
/*
 * Shared types and default widths for the execute stage.
 * Imported by the stage, the functional units and the operand interface.
 */
package exec_pkg;

    ////////////////////////////////////////
    // Default widths
    ////////////////////////////////////////
    localparam int XLEN_DEF  = 32;          // Data path width
    localparam int TAG_W_DEF = 4;           // Instruction tag width

    ////////////////////////////////////////
    // Functional unit selector
    ////////////////////////////////////////
    typedef enum logic [2:0] {
        XU_ALU    = 3'd0,                   // Add, sub, compare, logic
        XU_SHIFT  = 3'd1,                   // Barrel shifter
        XU_BRANCH = 3'd2,                   // Conditional branch, jal, jalr
        XU_LSU    = 3'd3,                   // Address and store alignment
        XU_BYPASS = 3'd4                    // Operand b straight to result
    } xu_sel_e;

    ////////////////////////////////////////
    // Operation codes
    ////////////////////////////////////////
    typedef enum logic [4:0] {
        OP_NOP  = 5'd0,                     // Idle unit
        OP_ADD  = 5'd1,
        OP_SUB  = 5'd2,
        OP_SLT  = 5'd3,                     // Signed compare
        OP_SLTU = 5'd4,                     // Unsigned compare
        OP_XOR  = 5'd5,
        OP_OR   = 5'd6,
        OP_AND  = 5'd7,
        OP_SLL  = 5'd8,
        OP_SRL  = 5'd9,
        OP_SRA  = 5'd10,                    // Sign fill
        OP_BEQ  = 5'd11,
        OP_BNE  = 5'd12,
        OP_BLT  = 5'd13,
        OP_BGE  = 5'd14,
        OP_BLTU = 5'd15,
        OP_BGEU = 5'd16,
        OP_JAL  = 5'd17,                    // Link to npc
        OP_JALR = 5'd18,                    // Register based target
        OP_LB   = 5'd19,
        OP_LH   = 5'd20,
        OP_LW   = 5'd21,
        OP_SB   = 5'd22,
        OP_SH   = 5'd23,
        OP_SW   = 5'd24
    } exec_op_e;

endpackage

//--- design/exec_top.sv
/*
 * Execute stage top level with plain ports.
 * Bundles the incoming operation into the operand interface.
 */
`timescale 1ns/100ps

module exec_top #(
    parameter int XLEN  = exec_pkg::XLEN_DEF,
    parameter int TAG_W = exec_pkg::TAG_W_DEF
) (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               in_valid_i,     // Upstream offers an operation
    input  exec_pkg::xu_sel_e  xu_sel_i,       // Unit selector
    input  exec_pkg::exec_op_e op_i,           // Operation code
    input  logic [XLEN-1:0]    op_a_i,
    input  logic [XLEN-1:0]    op_b_i,
    input  logic [XLEN-1:0]    op_c_i,
    input  logic [XLEN-1:0]    npc_i,
    input  logic [TAG_W-1:0]   tag_i,
    input  logic               out_ready_i,    // Downstream can take
    output logic               in_ready_o,
    output logic               out_valid_o,
    output logic [XLEN-1:0]    result_o,       // Main result
    output logic [XLEN-1:0]    result_aux_o,   // Target or address
    output logic [XLEN-1:0]    mem_addr_o,
    output logic               jump_o,
    output logic               we_rf_o,
    output logic               mem_rd_o,
    output logic [XLEN/8-1:0]  we_mem_o,       // Byte write mask
    output logic [TAG_W-1:0]   tag_o
);

    exec_op_if #(.XLEN(XLEN)) req_if ();    // Operation bundle

    ////////////////////////////////////////
    // Bundle request fields
    ////////////////////////////////////////
    assign req_if.op   = op_i;
    assign req_if.op_a = op_a_i;
    assign req_if.op_b = op_b_i;
    assign req_if.op_c = op_c_i;
    assign req_if.npc  = npc_i;

    execute_stage #(
        .XLEN  (XLEN),
        .TAG_W (TAG_W)
    ) u_stage (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .req          (req_if),
        .xu_sel_i     (xu_sel_i),
        .tag_i        (tag_i),
        .in_valid_i   (in_valid_i),
        .out_ready_i  (out_ready_i),
        .in_ready_o   (in_ready_o),
        .out_valid_o  (out_valid_o),
        .result_o     (result_o),
        .result_aux_o (result_aux_o),
        .mem_addr_o   (mem_addr_o),
        .jump_o       (jump_o),
        .we_rf_o      (we_rf_o),
        .mem_rd_o     (mem_rd_o),
        .we_mem_o     (we_mem_o),
        .tag_o        (tag_o)
    );

endmodule

//--- design/execute_stage.sv
/*
 * Execute stage: dispatches operands to the selected unit, collects its
 * results and holds them in one output register under valid/ready flow.
 */
`timescale 1ns/100ps

module execute_stage #(
    parameter int XLEN  = exec_pkg::XLEN_DEF,
    parameter int TAG_W = exec_pkg::TAG_W_DEF
) (
    input  logic               clk,
    input  logic               rst_n_i,        // Synchronous, active low
    exec_op_if.unit            req,            // Incoming operation
    input  exec_pkg::xu_sel_e  xu_sel_i,       // Target unit
    input  logic [TAG_W-1:0]   tag_i,
    input  logic               in_valid_i,
    input  logic               out_ready_i,
    output logic               in_ready_o,
    output logic               out_valid_o,
    output logic [XLEN-1:0]    result_o,
    output logic [XLEN-1:0]    result_aux_o,
    output logic [XLEN-1:0]    mem_addr_o,
    output logic               jump_o,
    output logic               we_rf_o,
    output logic               mem_rd_o,
    output logic [XLEN/8-1:0]  we_mem_o,
    output logic [TAG_W-1:0]   tag_o
);
    import exec_pkg::*;

    exec_op_if #(.XLEN(XLEN)) alu_if ();
    exec_op_if #(.XLEN(XLEN)) sh_if ();
    exec_op_if #(.XLEN(XLEN)) br_if ();
    exec_op_if #(.XLEN(XLEN)) ls_if ();

    logic [XLEN-1:0]   alu_res, sh_res;     // Unit outputs
    logic [XLEN-1:0]   br_res, br_tgt;
    logic              br_jump, br_we;
    logic [XLEN-1:0]   ls_addr, ls_wdata;
    logic              ls_rd, ls_we;
    logic [XLEN/8-1:0] ls_mask;
    logic [XLEN-1:0]   nxt_res, nxt_aux, nxt_addr; // Demux outputs
    logic              nxt_jump, nxt_we, nxt_rd;
    logic [XLEN/8-1:0] nxt_mask;
    logic              accept;              // Input transfer this cycle

    ////////////////////////////////////////
    // Dispatcher
    ////////////////////////////////////////
    assign alu_if.op = (xu_sel_i == XU_ALU)    ? req.op : OP_NOP;
    assign sh_if.op  = (xu_sel_i == XU_SHIFT)  ? req.op : OP_NOP;
    assign br_if.op  = (xu_sel_i == XU_BRANCH) ? req.op : OP_NOP;
    assign ls_if.op  = (xu_sel_i == XU_LSU)    ? req.op : OP_NOP;
    assign {alu_if.op_a, alu_if.op_b, alu_if.op_c, alu_if.npc} =
           {req.op_a, req.op_b, req.op_c, req.npc};
    assign {sh_if.op_a, sh_if.op_b, sh_if.op_c, sh_if.npc} =
           {req.op_a, req.op_b, req.op_c, req.npc};
    assign {br_if.op_a, br_if.op_b, br_if.op_c, br_if.npc} =
           {req.op_a, req.op_b, req.op_c, req.npc};
    assign {ls_if.op_a, ls_if.op_b, ls_if.op_c, ls_if.npc} =
           {req.op_a, req.op_b, req.op_c, req.npc};

    alu_unit    #(.XLEN(XLEN)) u_alu (.ops(alu_if), .result_o(alu_res));
    shift_unit  #(.XLEN(XLEN)) u_sh  (.ops(sh_if),  .result_o(sh_res));
    branch_unit #(.XLEN(XLEN)) u_br  (.ops(br_if), .result_o(br_res), .target_o(br_tgt),
                                      .jump_o(br_jump), .we_rf_o(br_we));
    lsu_unit    #(.XLEN(XLEN)) u_lsu (.ops(ls_if), .addr_o(ls_addr), .rd_o(ls_rd),
                                      .we_mem_o(ls_mask), .wdata_o(ls_wdata),
                                      .we_rf_o(ls_we));

    ////////////////////////////////////////
    // Result demux
    ////////////////////////////////////////
    always_comb begin
        nxt_res  = '0;                      // Unknown selector gives nothing
        nxt_aux  = '0;
        nxt_addr = '0;
        nxt_jump = 1'b0;
        nxt_we   = 1'b0;
        nxt_rd   = 1'b0;
        nxt_mask = '0;
        case (xu_sel_i)
            XU_ALU:    {nxt_res, nxt_we} = {alu_res, 1'b1};
            XU_SHIFT:  {nxt_res, nxt_we} = {sh_res, 1'b1};
            XU_BYPASS: {nxt_res, nxt_we} = {req.op_b, 1'b1};
            XU_BRANCH: begin
                {nxt_res, nxt_aux} = {br_res, br_tgt}; // Link, target
                {nxt_jump, nxt_we} = {br_jump, br_we};
            end
            XU_LSU: begin
                {nxt_res, nxt_aux, nxt_addr} = {ls_wdata, ls_addr, ls_addr};
                {nxt_we, nxt_rd, nxt_mask}   = {ls_we, ls_rd, ls_mask};
            end
            default: nxt_we = 1'b0;
        endcase
    end

    ////////////////////////////////////////
    // Handshake and output register
    ////////////////////////////////////////
    assign in_ready_o = !out_valid_o || out_ready_i; // Empty or draining
    assign accept     = in_valid_i && in_ready_o;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            out_valid_o <= 1'b0;
            {jump_o, we_rf_o, mem_rd_o} <= 3'b000;
            we_mem_o    <= '0;
        end else if (accept) begin
            out_valid_o <= 1'b1;            // Visible next cycle
            {jump_o, we_rf_o, mem_rd_o} <= {nxt_jump, nxt_we, nxt_rd};
            we_mem_o    <= nxt_mask;
        end else if (out_ready_i) begin
            out_valid_o <= 1'b0;            // Drained, nothing new
        end
    end

    always_ff @(posedge clk) begin          // Payload, loaded on accept only
        if (accept) begin
            {result_o, result_aux_o, mem_addr_o} <= {nxt_res, nxt_aux, nxt_addr};
            tag_o <= tag_i;
        end
    end

endmodule

//--- design/lsu_unit.sv
/*
 * Load/store address generation, read strobe, byte mask and store lane shift.
 * Data memory sits outside; this unit only prepares the access.
 */
`timescale 1ns/100ps

module lsu_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEF
) (
    exec_op_if.unit           ops,          // Gated operation from dispatcher
    output logic [XLEN-1:0]   addr_o,       // Effective address
    output logic              rd_o,         // Load strobe
    output logic [XLEN/8-1:0] we_mem_o,     // Byte write mask
    output logic [XLEN-1:0]   wdata_o,      // Lane aligned store data
    output logic              we_rf_o       // Load write-back enable
);
    import exec_pkg::*;

    localparam int NB    = XLEN / 8;        // Bytes per word
    localparam int OFF_W = $clog2(NB);      // Byte offset width

    logic [OFF_W-1:0] off;                  // Byte offset in the word
    logic [OFF_W-1:0] off_h;                // Halfword aligned offset
    logic [XLEN-1:0]  st_data;              // op_c moved to its lane

    assign addr_o  = ops.op_a + ops.op_b;   // Base plus offset
    assign off     = addr_o[OFF_W-1:0];
    assign off_h   = {off[OFF_W-1:1], 1'b0}; // Bit 0 ignored
    assign st_data = ops.op_c << {off, 3'b000};

    ////////////////////////////////////////
    // Access decode
    ////////////////////////////////////////
    always_comb begin
        rd_o     = 1'b0;
        we_rf_o  = 1'b0;
        we_mem_o = '0;
        wdata_o  = '0;                      // Loads return zero here
        case (ops.op)
            OP_LB, OP_LH, OP_LW: begin
                rd_o    = 1'b1;
                we_rf_o = 1'b1;             // Loaded value goes to rd
            end
            OP_SB: begin
                we_mem_o = NB'(1) << off;   // Single byte
                wdata_o  = st_data;
            end
            OP_SH: begin
                we_mem_o = NB'(3) << off_h; // Two bytes
                wdata_o  = st_data;
            end
            OP_SW: begin
                we_mem_o = '1;              // Whole word
                wdata_o  = st_data;
            end
            default: begin
                rd_o = 1'b0;
            end
        endcase
    end

endmodule

//--- design/shift_unit.sv
/*
 * Combinational shifter. Shifts op_a by the low log2(XLEN) bits of op_b.
 */
`timescale 1ns/100ps

module shift_unit #(
    parameter int XLEN = exec_pkg::XLEN_DEF
) (
    exec_op_if.unit         ops,            // Gated operation from dispatcher
    output logic [XLEN-1:0] result_o        // Shifted value
);
    import exec_pkg::*;

    localparam int SH_W = $clog2(XLEN);     // 5 for RV32, 6 for RV64

    logic [SH_W-1:0] shamt;                 // Shift amount

    assign shamt = ops.op_b[SH_W-1:0];      // Upper bits ignored

    ////////////////////////////////////////
    // Shift select
    ////////////////////////////////////////
    always_comb begin
        result_o = '0;
        case (ops.op)
            OP_SLL: begin
                result_o = ops.op_a << shamt;   // Zero fill from right
            end
            OP_SRL: begin
                result_o = ops.op_a >> shamt;   // Zero fill from left
            end
            OP_SRA: begin
                // Signed operand makes >>> replicate the sign bit
                result_o = $signed(ops.op_a) >>> shamt;
            end
            default: begin
                result_o = '0;              // Idle or foreign code
            end
        endcase
    end

endmodule

//--- exec_core.f
+incdir+bench
design/exec_pkg.sv
design/exec_op_if.sv
design/alu_unit.sv
design/shift_unit.sv
design/branch_unit.sv
design/lsu_unit.sv
design/execute_stage.sv
design/exec_top.sv
bench/tb_exec_top.sv

//--- run_sim.sh
#!/bin/sh
# Builds the execute stage testbench with Verilator, runs it and scans the log.
# Exits non-zero unless the run printed its pass line.
cd "$(dirname "$0")" &&
rm -rf obj_dir sim.log &&
verilator --binary --timing -j 0 -f exec_core.f --top-module tb_exec_top -o tb_exec_top &&
./obj_dir/tb_exec_top > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
